//--- tx_dp_fifo_pkg.sv
// transmit lane buffer types
package tx_dp_fifo_pkg;

   // fabric side carries two 40-bit halves
   localparam int FABRIC_W = 80;
   localparam int FIFO_W   = 40;

   // buffer geometry
   localparam int FIFO_DEPTH = 32;
   localparam int PTR_W      = $clog2(FIFO_DEPTH);
   localparam int THR_W      = 5;

   // marker positions in the fabric word
   localparam int WR_MARK_BIT = 79;
   localparam int WM_LOW_BIT  = 39;

   typedef logic [FABRIC_W-1:0] fabric_word_t;
   typedef logic [FIFO_W-1:0]   fifo_word_t;
   typedef logic [PTR_W-1:0]    fifo_ptr_t;
   // one extra bit so a full buffer reads as 32
   typedef logic [PTR_W:0]      fifo_cnt_t;
   typedef logic [THR_W-1:0]    thresh_t;

   // single-port owner for one cycle
   typedef enum logic [1:0] {
      GNT_IDLE,
      GNT_WRITE,
      GNT_READ
   } arb_grant_e;

endpackage

//--- tx_dp_cfg_pkg.sv
// transmit lane register map
package tx_dp_cfg_pkg;
   import tx_dp_fifo_pkg::*;

   // apb widths
   localparam int APB_ADDR_W = 4;
   localparam int APB_DATA_W = 32;

   typedef logic [APB_ADDR_W-1:0] apb_addr_t;
   typedef logic [APB_DATA_W-1:0] apb_data_t;
   typedef logic [4:0]            ctrl_t;

   // ------------------------------
   // register offsets
   // ------------------------------
   localparam apb_addr_t ADDR_CTRL   = 4'h0;
   localparam apb_addr_t ADDR_THRESH = 4'h4;
   localparam apb_addr_t ADDR_STATUS = 4'h8;

   // ctrl bit positions
   localparam int CTRL_WM_EN    = 0;
   localparam int CTRL_DBL_WR   = 1;
   localparam int CTRL_STOP_WR  = 2;
   localparam int CTRL_STOP_RD  = 3;
   localparam int CTRL_UTEST    = 4;

   // thresh byte lanes
   localparam int THR_EMPTY_LSB  = 0;
   localparam int THR_PEMPTY_LSB = 8;
   localparam int THR_PFULL_LSB  = 16;
   localparam int THR_FULL_LSB   = 24;

   // status fields, bit 8 is also write-one-to-clear
   localparam int STAT_CNT_LSB    = 0;
   localparam int STAT_OVF_BIT    = 8;
   localparam int STAT_EMPTY_BIT  = 12;
   localparam int STAT_PEMPTY_BIT = 13;
   localparam int STAT_PFULL_BIT  = 14;
   localparam int STAT_FULL_BIT   = 15;

   // ------------------------------
   // reset values
   // ------------------------------
   localparam ctrl_t   CTRL_RST       = '0;
   localparam thresh_t THR_EMPTY_RST  = 5'd0;
   localparam thresh_t THR_PEMPTY_RST = 5'd4;
   localparam thresh_t THR_PFULL_RST  = 5'd24;
   localparam thresh_t THR_FULL_RST   = 5'd31;

endpackage

//--- tx_apb_regs.sv
// apb control and status registers
module tx_apb_regs
   import tx_dp_fifo_pkg::*;
   import tx_dp_cfg_pkg::*;
(
   input  logic      tx_clock_fifo_sclk,
   input  logic      tx_reset_fifo_sclk_rst_n,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  apb_data_t pwdata,
   input  fifo_cnt_t fifo_count,
   input  logic      fifo_empty,
   input  logic      fifo_pempty,
   input  logic      fifo_pfull,
   input  logic      fifo_full,
   input  logic      overflow,
   output apb_data_t prdata,
   output logic      pready,
   output logic      pslverr,
   output logic      wm_en,
   output logic      double_write,
   output logic      stop_write,
   output logic      stop_read,
   output logic      usertest_sel,
   output thresh_t   thr_empty,
   output thresh_t   thr_pempty,
   output thresh_t   thr_pfull,
   output thresh_t   thr_full,
   output logic      overflow_clr
);

   logic  access;
   logic  addr_ok;
   logic  wr_en;
   ctrl_t ctrl_q;

   // access phase is the second cycle, no wait states
   assign access  = psel & penable;
   assign addr_ok = paddr inside {ADDR_CTRL, ADDR_THRESH, ADDR_STATUS};
   assign wr_en   = access & pwrite & addr_ok;
   assign pready  = 1'b1;
   assign pslverr = access & ~addr_ok;

   // control bits out to the lane
   assign wm_en        = ctrl_q[CTRL_WM_EN];
   assign double_write = ctrl_q[CTRL_DBL_WR];
   assign stop_write   = ctrl_q[CTRL_STOP_WR];
   assign stop_read    = ctrl_q[CTRL_STOP_RD];
   assign usertest_sel = ctrl_q[CTRL_UTEST];

   // ------------------------------
   // register writes
   // ------------------------------
   always_ff @(posedge tx_clock_fifo_sclk) begin
      if (!tx_reset_fifo_sclk_rst_n) begin
         ctrl_q       <= CTRL_RST;
         thr_empty    <= THR_EMPTY_RST;
         thr_pempty   <= THR_PEMPTY_RST;
         thr_pfull    <= THR_PFULL_RST;
         thr_full     <= THR_FULL_RST;
         overflow_clr <= 1'b0;
      end else begin
         // one-cycle clear strobe toward the arbiter
         overflow_clr <= wr_en && (paddr == ADDR_STATUS) && pwdata[STAT_OVF_BIT];
         if (wr_en && (paddr == ADDR_CTRL)) begin
            ctrl_q <= pwdata[$bits(ctrl_t)-1:0];
         end
         if (wr_en && (paddr == ADDR_THRESH)) begin
            thr_empty  <= pwdata[THR_EMPTY_LSB +: $bits(thresh_t)];
            thr_pempty <= pwdata[THR_PEMPTY_LSB +: $bits(thresh_t)];
            thr_pfull  <= pwdata[THR_PFULL_LSB +: $bits(thresh_t)];
            thr_full   <= pwdata[THR_FULL_LSB +: $bits(thresh_t)];
         end
      end
   end

   // readback mux, unknown offsets read as zero
   always_comb begin
      prdata = '0;
      case (paddr)
         ADDR_CTRL: prdata[$bits(ctrl_t)-1:0] = ctrl_q;
         ADDR_THRESH: begin
            prdata[THR_EMPTY_LSB +: $bits(thresh_t)]  = thr_empty;
            prdata[THR_PEMPTY_LSB +: $bits(thresh_t)] = thr_pempty;
            prdata[THR_PFULL_LSB +: $bits(thresh_t)]  = thr_pfull;
            prdata[THR_FULL_LSB +: $bits(thresh_t)]   = thr_full;
         end
         ADDR_STATUS: begin
            // live values straight from the arbiter
            prdata[STAT_CNT_LSB +: $bits(fifo_cnt_t)] = fifo_count;
            prdata[STAT_OVF_BIT]    = overflow;
            prdata[STAT_EMPTY_BIT]  = fifo_empty;
            prdata[STAT_PEMPTY_BIT] = fifo_pempty;
            prdata[STAT_PFULL_BIT]  = fifo_pfull;
            prdata[STAT_FULL_BIT]   = fifo_full;
         end
         default: prdata = '0;
      endcase
   end

   // enable only ever follows a select
   a_penable_needs_psel: assert property (
      @(posedge tx_clock_fifo_sclk) disable iff (!tx_reset_fifo_sclk_rst_n)
      $rose(penable) |-> psel
   ) else $error("penable rose without psel");

endmodule

//--- tx_fabric_writer.sv
// fabric word writer
module tx_fabric_writer
   import tx_dp_fifo_pkg::*;
(
   input  logic         tx_clock_fifo_sclk,
   input  logic         tx_reset_fifo_sclk_rst_n,
   input  fabric_word_t pld_tx_fabric_data_in,
   input  logic         wm_en,
   input  logic         double_write,
   input  logic         stop_write,
   output logic         wr_req,
   output fifo_word_t   wr_data
);

   logic         mark;
   logic         hi_pend_q;
   fabric_word_t stripped;
   fifo_word_t   hi_q;

   // marker sampled from the raw word, before stripping
   assign mark = pld_tx_fabric_data_in[WR_MARK_BIT] & ~stop_write;

   // word-mark removal on both halves
   always_comb begin
      stripped = pld_tx_fabric_data_in;
      if (wm_en) begin
         stripped[WM_LOW_BIT]  = 1'b0;
         stripped[WR_MARK_BIT] = 1'b0;
      end
   end

   // request sequencing: low half, then high half when doubled
   always_ff @(posedge tx_clock_fifo_sclk) begin
      if (!tx_reset_fifo_sclk_rst_n) begin
         wr_req    <= 1'b0;
         hi_pend_q <= 1'b0;
      end else begin
         wr_req    <= mark | hi_pend_q;
         hi_pend_q <= mark & double_write;
      end
   end

   // payload holding, high half parked for its second write
   always_ff @(posedge tx_clock_fifo_sclk) begin
      if (mark) begin
         wr_data <= stripped[FIFO_W-1:0];
         hi_q    <= stripped[FABRIC_W-1:FIFO_W];
      end else if (hi_pend_q) begin
         wr_data <= hi_q;
      end
   end

   // doubled words need a free cycle for the high half
   a_dbl_write_spacing: assert property (
      @(posedge tx_clock_fifo_sclk) disable iff (!tx_reset_fifo_sclk_rst_n)
      (mark && double_write) |=> !mark
   ) else $error("fabric word arrived during high-half write");

endmodule

//--- tx_fifo_arbiter.sv
// single-port buffer arbiter
module tx_fifo_arbiter
   import tx_dp_fifo_pkg::*;
(
   input  logic       tx_clock_fifo_sclk,
   input  logic       tx_reset_fifo_sclk_rst_n,
   input  logic       wr_req,
   input  fifo_word_t wr_data,
   input  logic       rd_req,
   input  thresh_t    thr_empty,
   input  thresh_t    thr_pempty,
   input  thresh_t    thr_pfull,
   input  thresh_t    thr_full,
   input  logic       overflow_clr,
   output logic       rd_gnt,
   output logic       ram_en,
   output logic       ram_we,
   output fifo_ptr_t  ram_addr,
   output fifo_word_t ram_wdata,
   output fifo_cnt_t  fifo_count,
   output logic       fifo_empty,
   output logic       fifo_pempty,
   output logic       fifo_pfull,
   output logic       fifo_full,
   output logic       overflow
);

   arb_grant_e grant;
   logic       do_write;
   logic       do_read;
   fifo_ptr_t  wr_ptr_q;
   fifo_ptr_t  rd_ptr_q;

   // writes always win, reads only into a free slot
   always_comb begin
      if (wr_req) begin
         grant = GNT_WRITE;
      end else if (rd_req && (fifo_count != '0)) begin
         grant = GNT_READ;
      end else begin
         grant = GNT_IDLE;
      end
   end

   // a write at full occupancy is granted but lost
   assign do_write = (grant == GNT_WRITE) && (fifo_count != fifo_cnt_t'(FIFO_DEPTH));
   assign do_read  = (grant == GNT_READ);

   // ------------------------------
   // pointers, occupancy, port strobes
   // ------------------------------
   always_ff @(posedge tx_clock_fifo_sclk) begin
      if (!tx_reset_fifo_sclk_rst_n) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         fifo_count <= '0;
         overflow   <= 1'b0;
         rd_gnt     <= 1'b0;
         ram_en     <= 1'b0;
         ram_we     <= 1'b0;
      end else begin
         // pointers wrap at 32 by width
         if (do_write) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_read) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // grants are exclusive, so at most one step per cycle
         if (do_write) begin
            fifo_count <= fifo_count + 1'b1;
         end else if (do_read) begin
            fifo_count <= fifo_count - 1'b1;
         end
         // sticky drop flag, a new drop beats the clear
         if ((grant == GNT_WRITE) && !do_write) begin
            overflow <= 1'b1;
         end else if (overflow_clr) begin
            overflow <= 1'b0;
         end
         rd_gnt <= do_read;
         ram_en <= do_write | do_read;
         ram_we <= do_write;
      end
   end

   // registered address and write data for the ram
   always_ff @(posedge tx_clock_fifo_sclk) begin
      ram_addr  <= do_write ? wr_ptr_q : rd_ptr_q;
      ram_wdata <= wr_data;
   end

   // level flags against software thresholds
   assign fifo_empty  = fifo_count <= fifo_cnt_t'(thr_empty);
   assign fifo_pempty = fifo_count <= fifo_cnt_t'(thr_pempty);
   assign fifo_pfull  = fifo_count >= fifo_cnt_t'(thr_pfull);
   assign fifo_full   = fifo_count >= fifo_cnt_t'(thr_full);

   a_no_empty_read: assert property (
      @(posedge tx_clock_fifo_sclk) disable iff (!tx_reset_fifo_sclk_rst_n)
      rd_gnt |-> ($past(fifo_count) != '0)
   ) else $error("read granted on an empty buffer");

   a_count_bound: assert property (
      @(posedge tx_clock_fifo_sclk) disable iff (!tx_reset_fifo_sclk_rst_n)
      fifo_count <= fifo_cnt_t'(FIFO_DEPTH)
   ) else $error("occupancy above buffer depth");

endmodule

//--- tx_fifo_ram.sv
// 32 by 40 single-port buffer
module tx_fifo_ram
   import tx_dp_fifo_pkg::*;
(
   input  logic       tx_clock_fifo_sclk,
   input  logic       ram_en,
   input  logic       ram_we,
   input  fifo_ptr_t  ram_addr,
   input  fifo_word_t ram_wdata,
   output fifo_word_t ram_rdata
);

   fifo_word_t mem [FIFO_DEPTH];

   // one access per cycle, read data lands a cycle later
   always_ff @(posedge tx_clock_fifo_sclk) begin
      if (ram_en) begin
         if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
         end else begin
            // rdata holds across writes
            ram_rdata <= mem[ram_addr];
         end
      end
   end

endmodule

//--- tx_fifo_reader.sv
// aib-side read pipeline
module tx_fifo_reader
   import tx_dp_fifo_pkg::*;
(
   input  logic       tx_clock_fifo_sclk,
   input  logic       tx_reset_fifo_sclk_rst_n,
   input  logic       stop_read,
   input  logic       rd_gnt,
   input  fifo_word_t ram_rdata,
   output logic       rd_req,
   output fifo_word_t aib_fabric_tx_data_out,
   output logic       tx_data_valid
);

   logic rd_vld_q;

   // keep asking unless software holds the reader
   assign rd_req = ~stop_read;

   // ------------------------------
   // valid pipeline
   // ------------------------------
   // stage one marks ram_rdata, stage two the output register
   always_ff @(posedge tx_clock_fifo_sclk) begin
      if (!tx_reset_fifo_sclk_rst_n) begin
         rd_vld_q      <= 1'b0;
         tx_data_valid <= 1'b0;
      end else begin
         rd_vld_q      <= rd_gnt;
         tx_data_valid <= rd_vld_q;
      end
   end

   // output keeps its last word between valid cycles
   always_ff @(posedge tx_clock_fifo_sclk) begin
      if (rd_vld_q) begin
         aib_fabric_tx_data_out <= ram_rdata;
      end
   end

endmodule

//--- tx_freeze_gate.sv
// freeze gating toward the fabric
module tx_freeze_gate (
   input  logic tx_clock_fifo_sclk,
   input  logic tx_reset_fifo_sclk_rst_n,
   input  logic nfrzdrv_in,
   input  logic pr_channel_freeze_n,
   input  logic usertest_sel,
   input  logic aib_fabric_pld_tx_hssi_fifo_latency_pulse,
   input  logic fifo_empty,
   input  logic fifo_pempty,
   input  logic fifo_pfull,
   input  logic fifo_full,
   output logic pld_tx_fabric_fifo_empty,
   output logic pld_tx_fabric_fifo_pempty,
   output logic pld_tx_fabric_fifo_pfull,
   output logic pld_tx_fabric_fifo_full,
   output logic pld_tx_hssi_fifo_latency_pulse
);

   logic lat_pulse_q;
   logic lat_pulse_sel;
   logic nfrz;

   // one-cycle copy of the hssi pulse
   always_ff @(posedge tx_clock_fifo_sclk) begin
      if (!tx_reset_fifo_sclk_rst_n) begin
         lat_pulse_q <= 1'b0;
      end else begin
         lat_pulse_q <= aib_fabric_pld_tx_hssi_fifo_latency_pulse;
      end
   end

   // user-test picks the registered copy
   assign lat_pulse_sel = usertest_sel ? lat_pulse_q
                                       : aib_fabric_pld_tx_hssi_fifo_latency_pulse;

   // either freeze input low drives everything high
   assign nfrz = nfrzdrv_in & pr_channel_freeze_n;

   assign pld_tx_fabric_fifo_empty       = nfrz ? fifo_empty : 1'b1;
   assign pld_tx_fabric_fifo_pempty      = nfrz ? fifo_pempty : 1'b1;
   assign pld_tx_fabric_fifo_pfull       = nfrz ? fifo_pfull : 1'b1;
   assign pld_tx_fabric_fifo_full        = nfrz ? fifo_full : 1'b1;
   assign pld_tx_hssi_fifo_latency_pulse = nfrz ? lat_pulse_sel : 1'b1;

endmodule

//--- tx_datapath_top.sv
// transmit adapter lane top
module tx_datapath_top
   import tx_dp_fifo_pkg::*;
   import tx_dp_cfg_pkg::*;
(
   input  logic         tx_clock_fifo_sclk,
   input  logic         tx_reset_fifo_sclk_rst_n,
   input  logic         psel,
   input  logic         penable,
   input  logic         pwrite,
   input  apb_addr_t    paddr,
   input  apb_data_t    pwdata,
   input  fabric_word_t pld_tx_fabric_data_in,
   input  logic         nfrzdrv_in,
   input  logic         pr_channel_freeze_n,
   input  logic         aib_fabric_pld_tx_hssi_fifo_latency_pulse,
   output apb_data_t    prdata,
   output logic         pready,
   output logic         pslverr,
   output fifo_word_t   aib_fabric_tx_data_out,
   output logic         tx_data_valid,
   output logic         pld_tx_fabric_fifo_empty,
   output logic         pld_tx_fabric_fifo_pempty,
   output logic         pld_tx_fabric_fifo_pfull,
   output logic         pld_tx_fabric_fifo_full,
   output logic         pld_tx_hssi_fifo_latency_pulse
);

   // configuration
   logic       wm_en;
   logic       double_write;
   logic       stop_write;
   logic       stop_read;
   logic       usertest_sel;
   thresh_t    thr_empty;
   thresh_t    thr_pempty;
   thresh_t    thr_pfull;
   thresh_t    thr_full;
   logic       overflow_clr;

   // write and read peers
   logic       wr_req;
   fifo_word_t wr_data;
   logic       rd_req;
   logic       rd_gnt;

   // buffer port and status
   logic       ram_en;
   logic       ram_we;
   fifo_ptr_t  ram_addr;
   fifo_word_t ram_wdata;
   fifo_word_t ram_rdata;
   fifo_cnt_t  fifo_count;
   logic       fifo_empty;
   logic       fifo_pempty;
   logic       fifo_pfull;
   logic       fifo_full;
   logic       overflow;

   tx_apb_regs i_tx_apb_regs (.*);

   tx_fabric_writer i_tx_fabric_writer (.*);

   // sole owner of the ram port
   tx_fifo_arbiter i_tx_fifo_arbiter (.*);

   tx_fifo_ram i_tx_fifo_ram (.*);

   tx_fifo_reader i_tx_fifo_reader (.*);

   tx_freeze_gate i_tx_freeze_gate (.*);

endmodule

//--- tb_tx_datapath.sv
// transmit lane directed testbench
module tb_tx_datapath
   import tx_dp_fifo_pkg::*;
   import tx_dp_cfg_pkg::*;
();

   // threshold values expected out of reset
   localparam int EXP_THR_EMPTY  = 0;
   localparam int EXP_THR_PEMPTY = 4;
   localparam int EXP_THR_PFULL  = 24;
   localparam int EXP_THR_FULL   = 31;

   logic         tx_clock_fifo_sclk;
   logic         tx_reset_fifo_sclk_rst_n;
   logic         psel;
   logic         penable;
   logic         pwrite;
   apb_addr_t    paddr;
   apb_data_t    pwdata;
   apb_data_t    prdata;
   logic         pready;
   logic         pslverr;
   fabric_word_t pld_tx_fabric_data_in;
   logic         nfrzdrv_in;
   logic         pr_channel_freeze_n;
   logic         aib_fabric_pld_tx_hssi_fifo_latency_pulse;
   fifo_word_t   aib_fabric_tx_data_out;
   logic         tx_data_valid;
   logic         pld_tx_fabric_fifo_empty;
   logic         pld_tx_fabric_fifo_pempty;
   logic         pld_tx_fabric_fifo_pfull;
   logic         pld_tx_fabric_fifo_full;
   logic         pld_tx_hssi_fifo_latency_pulse;

   // model state
   fifo_word_t   exp_q[$];
   bit           cur_wm;
   bit           cur_dbl;
   bit           cur_stop_rd;
   bit           exp_ovf;
   logic         last_slverr;
   int           n_mismatch;
   int           n_other;

   tx_datapath_top i_tx_datapath_top (.*);

   initial begin
      tx_clock_fifo_sclk = 1'b0;
      forever #5 tx_clock_fifo_sclk = ~tx_clock_fifo_sclk;
   end

   // ------------------------------
   // checking helpers
   // ------------------------------
   task automatic check_eq(input string sig, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) else begin
         n_mismatch++;
         $display("FAIL time=%0t %s got=%0h expected=%0h", $time, sig, got, exp);
      end
   endtask

   // status word rebuilt from the threshold rules
   function automatic apb_data_t expect_status(input int cnt, input bit ovf);
      apb_data_t s;
      s      = '0;
      s[5:0] = cnt[5:0];
      s[8]   = ovf;
      s[12]  = (cnt <= EXP_THR_EMPTY);
      s[13]  = (cnt <= EXP_THR_PEMPTY);
      s[14]  = (cnt >= EXP_THR_PFULL);
      s[15]  = (cnt >= EXP_THR_FULL);
      return s;
   endfunction

   // every valid output word must match the head of the model
   always @(negedge tx_clock_fifo_sclk) begin
      if (tx_reset_fifo_sclk_rst_n && tx_data_valid) begin
         assert (exp_q.size() != 0) else begin
            n_other++;
            $display("ERROR time=%0t output word %0h arrived with none expected",
                     $time, aib_fabric_tx_data_out);
         end
         if (exp_q.size() != 0) begin
            check_eq("aib_fabric_tx_data_out", aib_fabric_tx_data_out, exp_q.pop_front());
         end
      end
   end

   // ------------------------------
   // apb access
   // ------------------------------
   task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                             output apb_data_t rdata);
      int n;
      @(posedge tx_clock_fifo_sclk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge tx_clock_fifo_sclk);
      penable <= 1'b1;
      // access phase closes on the first edge with pready
      n = 0;
      @(posedge tx_clock_fifo_sclk);
      while (!pready && n < 16) begin
         @(posedge tx_clock_fifo_sclk);
         n++;
      end
      assert (pready) else begin
         n_other++;
         $display("ERROR time=%0t apb slave never raised pready", $time);
      end
      rdata       = prdata;
      last_slverr = pslverr;
      psel        <= 1'b0;
      penable     <= 1'b0;
   endtask

   task automatic apb_write(input apb_addr_t addr, input apb_data_t wdata);
      apb_data_t unused;
      apb_access(1'b1, addr, wdata, unused);
   endtask

   task automatic apb_read(input apb_addr_t addr, output apb_data_t rdata);
      apb_access(1'b0, addr, '0, rdata);
   endtask

   // ctrl bits: wm_en 0, double_write 1, stop_write 2, stop_read 3, usertest 4
   task automatic set_ctrl(input bit wm, input bit dbl, input bit stop_rd, input bit utest);
      cur_wm      = wm;
      cur_dbl     = dbl;
      cur_stop_rd = stop_rd;
      apb_write(ADDR_CTRL, {27'b0, utest, stop_rd, 1'b0, dbl, wm});
   endtask

   // ------------------------------
   // fabric side and model
   // ------------------------------
   // bit 79 marks a write, bit 39 is the low-half word mark
   function automatic void model_push(input fabric_word_t w);
      if (w[79]) begin
         if (cur_stop_rd && exp_q.size() >= 32) begin
            exp_ovf = 1'b1;
         end else begin
            if (cur_wm) begin
               w[39] = 1'b0;
               w[79] = 1'b0;
            end
            exp_q.push_back(w[39:0]);
            if (cur_dbl) begin
               exp_q.push_back(w[79:40]);
            end
         end
      end
   endfunction

   function automatic fabric_word_t random_word(input bit mark);
      fabric_word_t w;
      w[79:64] = 16'($urandom());
      w[63:32] = $urandom();
      w[31:0]  = $urandom();
      w[79]    = mark;
      return w;
   endfunction

   task automatic send_word(input fabric_word_t w);
      @(posedge tx_clock_fifo_sclk);
      pld_tx_fabric_data_in <= w;
      model_push(w);
   endtask

   task automatic wait_drained(input int limit);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < limit) begin
         @(posedge tx_clock_fifo_sclk);
         n++;
      end
      assert (exp_q.size() == 0) else begin
         n_other++;
         $display("ERROR time=%0t timed out with %0d words never output", $time, exp_q.size());
         exp_q.delete();
      end
      // idle so that stray words show up in the monitor
      repeat (4) @(posedge tx_clock_fifo_sclk);
   endtask

   // ------------------------------
   // directed tests
   // ------------------------------
   task automatic test_registers();
      apb_data_t rd;
      apb_data_t wv;
      check_eq("tx_data_valid", tx_data_valid, 1'b0);
      apb_read(ADDR_CTRL, rd);
      check_eq("ctrl", rd, 32'h0);
      apb_read(ADDR_THRESH, rd);
      check_eq("thresh", rd, 32'h1f18_0400);
      apb_read(ADDR_STATUS, rd);
      check_eq("status", rd, expect_status(0, 1'b0));
      // only the defined bits stick
      wv = $urandom();
      apb_write(ADDR_CTRL, wv);
      apb_read(ADDR_CTRL, rd);
      check_eq("ctrl", rd, wv & 32'h1f);
      wv = $urandom();
      apb_write(ADDR_THRESH, wv);
      apb_read(ADDR_THRESH, rd);
      check_eq("thresh", rd, wv & 32'h1f1f_1f1f);
      apb_write(ADDR_THRESH, 32'h1f18_0400);
      set_ctrl(1'b0, 1'b0, 1'b0, 1'b0);
      // unmapped offset errors out and leaves ctrl alone
      apb_write(4'hc, 32'hffff_ffff);
      check_eq("pslverr", last_slverr, 1'b1);
      apb_read(4'hc, rd);
      check_eq("pslverr", last_slverr, 1'b1);
      check_eq("prdata", rd, 32'h0);
      apb_read(ADDR_CTRL, rd);
      check_eq("ctrl", rd, 32'h0);
      check_eq("pslverr", last_slverr, 1'b0);
   endtask

   // marked and unmarked words mixed, back to back
   task automatic test_single_write(input bit wm);
      fabric_word_t w;
      set_ctrl(wm, 1'b0, 1'b0, 1'b0);
      for (int i = 0; i < 24; i++) begin
         w     = random_word(1'($urandom_range(0, 1)));
         w[39] = 1'b1;
         send_word(w);
      end
      send_word('0);
      wait_drained(200);
   endtask

   // one free cycle after every doubled word
   task automatic test_double_write(input bit wm);
      set_ctrl(wm, 1'b1, 1'b0, 1'b0);
      for (int i = 0; i < 12; i++) begin
         send_word(random_word(1'b1));
         send_word(random_word(1'b0));
      end
      send_word('0);
      wait_drained(300);
   endtask

   task automatic test_flags_overflow();
      apb_data_t rd;
      apb_data_t es;
      set_ctrl(1'b0, 1'b0, 1'b1, 1'b0);
      // fill past the depth, count held at 32 once full
      for (int n = 1; n <= 34; n++) begin
         send_word(random_word(1'b1));
         send_word('0);
         apb_read(ADDR_STATUS, rd);
         es = expect_status(exp_q.size(), exp_ovf);
         check_eq("status", rd, es);
         check_eq("pld_tx_fabric_fifo_empty", pld_tx_fabric_fifo_empty, es[12]);
         check_eq("pld_tx_fabric_fifo_pempty", pld_tx_fabric_fifo_pempty, es[13]);
         check_eq("pld_tx_fabric_fifo_pfull", pld_tx_fabric_fifo_pfull, es[14]);
         check_eq("pld_tx_fabric_fifo_full", pld_tx_fabric_fifo_full, es[15]);
      end
      check_eq("overflow", rd[8], 1'b1);
      // frozen while full, so the low flags are forced as well
      @(posedge tx_clock_fifo_sclk);
      nfrzdrv_in <= 1'b0;
      @(negedge tx_clock_fifo_sclk);
      check_frozen();
      @(posedge tx_clock_fifo_sclk);
      nfrzdrv_in <= 1'b1;
      apb_write(ADDR_STATUS, 32'h0000_0100);
      exp_ovf = 1'b0;
      apb_read(ADDR_STATUS, rd);
      check_eq("status", rd, expect_status(32, 1'b0));
      // release the reader and drain in order
      set_ctrl(1'b0, 1'b0, 1'b0, 1'b0);
      wait_drained(200);
      apb_read(ADDR_STATUS, rd);
      check_eq("status", rd, expect_status(0, 1'b0));
   endtask

   task automatic check_frozen();
      check_eq("pld_tx_fabric_fifo_empty", pld_tx_fabric_fifo_empty, 1'b1);
      check_eq("pld_tx_fabric_fifo_pempty", pld_tx_fabric_fifo_pempty, 1'b1);
      check_eq("pld_tx_fabric_fifo_pfull", pld_tx_fabric_fifo_pfull, 1'b1);
      check_eq("pld_tx_fabric_fifo_full", pld_tx_fabric_fifo_full, 1'b1);
      check_eq("pld_tx_hssi_fifo_latency_pulse", pld_tx_hssi_fifo_latency_pulse, 1'b1);
   endtask

   task automatic check_pulse(input bit registered);
      logic prev;
      logic now_v;
      for (int i = 0; i < 16; i++) begin
         @(posedge tx_clock_fifo_sclk);
         // value the pulse register takes at this edge
         prev  = aib_fabric_pld_tx_hssi_fifo_latency_pulse;
         now_v = 1'($urandom_range(0, 1));
         aib_fabric_pld_tx_hssi_fifo_latency_pulse <= now_v;
         @(negedge tx_clock_fifo_sclk);
         check_eq("pld_tx_hssi_fifo_latency_pulse", pld_tx_hssi_fifo_latency_pulse,
                  registered ? prev : now_v);
      end
   endtask

   task automatic test_freeze_pulse();
      @(posedge tx_clock_fifo_sclk);
      aib_fabric_pld_tx_hssi_fifo_latency_pulse <= 1'b0;
      nfrzdrv_in <= 1'b0;
      @(negedge tx_clock_fifo_sclk);
      check_frozen();
      @(posedge tx_clock_fifo_sclk);
      nfrzdrv_in          <= 1'b1;
      pr_channel_freeze_n <= 1'b0;
      @(negedge tx_clock_fifo_sclk);
      check_frozen();
      @(posedge tx_clock_fifo_sclk);
      pr_channel_freeze_n <= 1'b1;
      set_ctrl(1'b0, 1'b0, 1'b0, 1'b1);
      check_pulse(1'b1);
      set_ctrl(1'b0, 1'b0, 1'b0, 1'b0);
      check_pulse(1'b0);
   endtask

   initial begin
      int unused_seed;
      unused_seed = $urandom(32'hd48e6ba6);
      n_mismatch  = 0;
      n_other     = 0;
      cur_wm      = 1'b0;
      cur_dbl     = 1'b0;
      cur_stop_rd = 1'b0;
      exp_ovf     = 1'b0;
      last_slverr = 1'b0;
      tx_reset_fifo_sclk_rst_n = 1'b0;
      psel                     = 1'b0;
      penable                  = 1'b0;
      pwrite                   = 1'b0;
      paddr                    = '0;
      pwdata                   = '0;
      pld_tx_fabric_data_in    = '0;
      nfrzdrv_in               = 1'b1;
      pr_channel_freeze_n      = 1'b1;
      aib_fabric_pld_tx_hssi_fifo_latency_pulse = 1'b0;
      repeat (16) @(posedge tx_clock_fifo_sclk);
      tx_reset_fifo_sclk_rst_n <= 1'b1;
      test_registers();
      test_single_write(1'b0);
      test_single_write(1'b1);
      test_double_write(1'b0);
      test_double_write(1'b1);
      test_flags_overflow();
      test_freeze_pulse();
      repeat (4) @(posedge tx_clock_fifo_sclk);
      $display("error counts: %0d value mismatches, %0d other failures", n_mismatch, n_other);
      if (n_mismatch + n_other == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- all.f
tx_dp_fifo_pkg.sv
tx_dp_cfg_pkg.sv
tx_apb_regs.sv
tx_fabric_writer.sv
tx_fifo_arbiter.sv
tx_fifo_ram.sv
tx_fifo_reader.sv
tx_freeze_gate.sv
tx_datapath_top.sv
tb_tx_datapath.sv
